/* files.f */
+incdir+hw
hw/gmii_pkg.sv
hw/frame_tx_ctrl.sv
hw/frame_buffer.sv
hw/crc32_engine.sv
hw/gmii_tx_serializer.sv
hw/gmii_frame_gen.sv
test/gmii_frame_gen_props.sv
test/gmii_frame_gen_tb.sv

/* hw/crc32_engine.sv */
`timescale 1ns/1ns
`include "gmii_params.svh"

module crc32_engine (
  input  logic            gmii_tx_clk,
  input  logic            rst_n,
  input  logic            init,
  input  logic            en,
  input  gmii_pkg::byte_t data,
  output gmii_pkg::crc_t  fcs
);
  import gmii_pkg::*;

  crc_t crc_q;

  // Eight steps of the reflected shift register, LSB of the byte first
  function automatic crc_t crc_step(input crc_t crc_in, input byte_t d);
    crc_t c;
    logic fb;
    c = crc_in;
    for (int i = 0; i < 8; i++)
    begin
      fb = c[0] ^ d[i];
      c  = c >> 1;
      if (fb)
        c = c ^ `CRC32_POLY;
    end
    return c;
  endfunction

  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
      crc_q <= `CRC32_INIT;
    else if (init)
      crc_q <= `CRC32_INIT;
    else if (en)
      crc_q <= crc_step(crc_q, data);
  end

  assign fcs = ~crc_q;

endmodule

/* hw/frame_buffer.sv */
`timescale 1ns/1ns
`include "gmii_params.svh"

module frame_buffer (
  input  logic                gmii_tx_clk,
  input  logic                we,
  input  gmii_pkg::buf_addr_t addr,
  input  gmii_pkg::byte_t     wdata,
  output gmii_pkg::byte_t     rd_data
);
  import gmii_pkg::*;

  byte_t mem [0:`FRAME_BUF_DEPTH-1];

  // Host writes land here only while the generator is idle
  always_ff @(posedge gmii_tx_clk)
  begin
    if (we)
      mem[addr] <= wdata;
  end

  // Registered read, data follows the address by one cycle
  always_ff @(posedge gmii_tx_clk)
  begin
    rd_data <= mem[addr];
  end

endmodule

/* hw/frame_tx_ctrl.sv */
`timescale 1ns/1ns
`include "gmii_params.svh"

module frame_tx_ctrl (
  input  logic                gmii_tx_clk,
  input  logic                rst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  gmii_pkg::wb_addr_t  wb_adr,
  input  gmii_pkg::byte_t     wb_dat_w,
  input  gmii_pkg::byte_t     rd_data,
  output gmii_pkg::byte_t     wb_dat_r,
  output logic                wb_ack,
  output logic                buf_we,
  output gmii_pkg::buf_addr_t buf_addr,
  output gmii_pkg::byte_t     buf_wdata,
  output gmii_pkg::tx_phase_e phase,
  output logic [1:0]          fcs_idx,
  output logic                tx_er_req,
  output logic                crc_init,
  output logic                crc_en
);
  import gmii_pkg::*;

  tx_phase_e  state;
  frame_len_t cnt;
  frame_len_t frame_len;
  buf_addr_t  err_pos;
  logic       err_en;
  logic       busy;
  logic [6:0] frame_cnt;
  logic       armed;
  logic       req;
  logic       host_buf;
  logic       reg_wr;
  logic       start;
  byte_t      reg_rdata;

  // One request per strobe; strobe must drop before the next one
  assign req      = wb_cyc & wb_stb & armed;
  assign host_buf = ~wb_adr[6];
  assign reg_wr   = req & wb_we & ~busy;
  assign start    = reg_wr & (wb_adr == `REG_CTRL) & wb_dat_w[0];

  assign buf_we    = reg_wr & host_buf;
  assign buf_wdata = wb_dat_w;
  // FSM owns the address while it streams the payload
  assign buf_addr  = (state == PH_DATA) ? cnt[5:0] : wb_adr[5:0];

  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      armed  <= 1'b1;
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= req;
      if (req)
        armed <= 1'b0;
      else if (!(wb_cyc && wb_stb))
        armed <= 1'b1;
    end
  end

  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_len <= 7'd64;
      err_pos   <= '0;
      err_en    <= 1'b0;
    end
    else if (reg_wr)
    begin
      if (wb_adr == `REG_LEN)
        frame_len <= wb_dat_w[6:0];
      if (wb_adr == `REG_ERR_POS)
        err_pos <= wb_dat_w[5:0];
      if (wb_adr == `REG_CTRL)
        err_en <= wb_dat_w[1];
    end
  end

  always_comb
  begin
    case (wb_adr)
      `REG_LEN:     reg_rdata = {1'b0, frame_len};
      `REG_ERR_POS: reg_rdata = {2'b00, err_pos};
      `REG_CTRL:    reg_rdata = {6'b0, err_en, 1'b0};
      `REG_STATUS:  reg_rdata = {frame_cnt, busy};
      default:      reg_rdata = '0;
    endcase
    wb_dat_r = host_buf ? rd_data : reg_rdata;
  end

  // Frame sequencer, one shared byte counter
  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= PH_IDLE;
      cnt       <= '0;
      busy      <= 1'b0;
      frame_cnt <= '0;
    end
    else
    begin
      cnt <= cnt + 7'd1;
      case (state)
        PH_IDLE:
        begin
          cnt <= '0;
          if (start)
          begin
            state <= PH_PREAMBLE;
            busy  <= 1'b1;
          end
        end
        PH_PREAMBLE:
          if (cnt == 7'(`GMII_PREAMBLE_LEN - 1))
          begin
            state <= PH_SFD;
            cnt   <= '0;
          end
        PH_SFD:
        begin
          state <= PH_DATA;
          cnt   <= '0;
        end
        PH_DATA:
          if (cnt == frame_len - 7'd1)
          begin
            state <= PH_FCS;
            cnt   <= '0;
          end
        PH_FCS:
          if (cnt == 7'(`GMII_FCS_LEN - 1))
          begin
            state <= PH_GAP;
            cnt   <= '0;
          end
        PH_GAP:
          // Two extra cycles cover the delay stage and the output register
          if (cnt == 7'(`GMII_IFG_LEN + 1))
          begin
            state     <= PH_IDLE;
            busy      <= 1'b0;
            frame_cnt <= frame_cnt + 7'd1;
          end
        default:
          state <= PH_IDLE;
      endcase
    end
  end

  // Delay stage lines the phase up with buffer read data
  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase     <= PH_IDLE;
      fcs_idx   <= '0;
      tx_er_req <= 1'b0;
      crc_init  <= 1'b0;
      crc_en    <= 1'b0;
    end
    else
    begin
      phase     <= state;
      fcs_idx   <= cnt[1:0];
      tx_er_req <= err_en && (state == PH_DATA) && (cnt[5:0] == err_pos);
      crc_init  <= (state == PH_SFD);
      crc_en    <= (state == PH_DATA);
    end
  end

endmodule

/* hw/gmii_frame_gen.sv */
`timescale 1ns/1ns

module gmii_frame_gen (
  input  logic               gmii_tx_clk,
  input  logic               rst_n,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  gmii_pkg::wb_addr_t wb_adr,
  input  gmii_pkg::byte_t    wb_dat_w,
  output gmii_pkg::byte_t    wb_dat_r,
  output logic               wb_ack,
  output gmii_pkg::byte_t    gmii_txd,
  output logic               gmii_tx_en,
  output logic               gmii_tx_er
);

  logic                buf_we;
  gmii_pkg::buf_addr_t buf_addr;
  gmii_pkg::byte_t     buf_wdata;
  gmii_pkg::byte_t     rd_data;
  gmii_pkg::tx_phase_e phase;
  logic [1:0]          fcs_idx;
  logic                tx_er_req;
  logic                crc_init;
  logic                crc_en;
  gmii_pkg::crc_t      fcs;

  frame_tx_ctrl i_frame_tx_ctrl (
    .gmii_tx_clk (gmii_tx_clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .rd_data     (rd_data),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .buf_we      (buf_we),
    .buf_addr    (buf_addr),
    .buf_wdata   (buf_wdata),
    .phase       (phase),
    .fcs_idx     (fcs_idx),
    .tx_er_req   (tx_er_req),
    .crc_init    (crc_init),
    .crc_en      (crc_en)
  );

  frame_buffer i_frame_buffer (
    .gmii_tx_clk (gmii_tx_clk),
    .we          (buf_we),
    .addr        (buf_addr),
    .wdata       (buf_wdata),
    .rd_data     (rd_data)
  );

  // CRC sees the same buffer bytes the serializer sends
  crc32_engine i_crc32_engine (
    .gmii_tx_clk (gmii_tx_clk),
    .rst_n       (rst_n),
    .init        (crc_init),
    .en          (crc_en),
    .data        (rd_data),
    .fcs         (fcs)
  );

  gmii_tx_serializer i_gmii_tx_serializer (
    .gmii_tx_clk (gmii_tx_clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .fcs_idx     (fcs_idx),
    .tx_er_req   (tx_er_req),
    .rd_data     (rd_data),
    .fcs         (fcs),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_tx_er  (gmii_tx_er)
  );

endmodule

/* hw/gmii_params.svh */
`ifndef GMII_PARAMS_SVH
`define GMII_PARAMS_SVH

// GMII framing bytes
`define GMII_PREAMBLE_BYTE 8'h55
`define GMII_SFD_BYTE      8'hD5

// Frame field lengths in byte times
`define GMII_PREAMBLE_LEN  7
`define GMII_FCS_LEN       4
`define GMII_IFG_LEN       12

// Host frame memory
`define FRAME_BUF_DEPTH    64

// Ethernet CRC-32, reflected form
`define CRC32_POLY         32'hEDB88320
`define CRC32_INIT         32'hFFFFFFFF

// Wishbone register map, above the buffer window at 0..63
// Frame length, 1 to 64
`define REG_LEN            7'd64
// Index of the data byte that carries tx_er
`define REG_ERR_POS        7'd65
// Bit 0 start, bit 1 error enable
`define REG_CTRL           7'd66
// Bit 0 busy, bits 7:1 frame counter
`define REG_STATUS         7'd67

`endif

/* hw/gmii_pkg.sv */
package gmii_pkg;

  // GMII or Wishbone data byte
  typedef logic [7:0] byte_t;

  // CRC register and FCS
  typedef logic [31:0] crc_t;

  // Index into the frame buffer
  typedef logic [5:0] buf_addr_t;

  // Frame length, 1 to 64
  typedef logic [6:0] frame_len_t;

  // Wishbone byte address
  typedef logic [6:0] wb_addr_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_PREAMBLE,
    PH_SFD,
    PH_DATA,
    PH_FCS,
    PH_GAP
  } tx_phase_e;

endpackage

/* hw/gmii_tx_serializer.sv */
`timescale 1ns/1ns
`include "gmii_params.svh"

module gmii_tx_serializer (
  input  logic                gmii_tx_clk,
  input  logic                rst_n,
  input  gmii_pkg::tx_phase_e phase,
  input  logic [1:0]          fcs_idx,
  input  logic                tx_er_req,
  input  gmii_pkg::byte_t     rd_data,
  input  gmii_pkg::crc_t      fcs,
  output gmii_pkg::byte_t     gmii_txd,
  output logic                gmii_tx_en,
  output logic                gmii_tx_er
);
  import gmii_pkg::*;

  byte_t fcs_byte;

  // FCS goes out low byte first
  always_comb
  begin
    case (fcs_idx)
      2'd0:    fcs_byte = fcs[7:0];
      2'd1:    fcs_byte = fcs[15:8];
      2'd2:    fcs_byte = fcs[23:16];
      default: fcs_byte = fcs[31:24];
    endcase
  end

  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gmii_txd   <= '0;
      gmii_tx_en <= 1'b0;
      gmii_tx_er <= 1'b0;
    end
    else
    begin
      gmii_tx_en <= (phase == PH_PREAMBLE) || (phase == PH_SFD) ||
                    (phase == PH_DATA) || (phase == PH_FCS);
      // Error strobe only ever lands on a payload byte
      gmii_tx_er <= tx_er_req && (phase == PH_DATA);
      case (phase)
        PH_PREAMBLE: gmii_txd <= `GMII_PREAMBLE_BYTE;
        PH_SFD:      gmii_txd <= `GMII_SFD_BYTE;
        PH_DATA:     gmii_txd <= rd_data;
        PH_FCS:      gmii_txd <= fcs_byte;
        default:     gmii_txd <= '0;
      endcase
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the GMII frame generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f files.f --top-module gmii_frame_gen_tb \
  --Mdir "$BUILD_DIR" -o gmii_frame_gen_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/gmii_frame_gen_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

/* test/gmii_frame_gen_props.sv */
`timescale 1ns/1ns

module gmii_frame_gen_props (
  input logic gmii_tx_clk,
  input logic rst_n,
  input logic wb_ack,
  input logic gmii_tx_en,
  input logic gmii_tx_er
);

  // Consecutive cycles with tx_en high
  logic [7:0] en_run;

  always_ff @(posedge gmii_tx_clk or negedge rst_n)
  begin
    if (!rst_n)
      en_run <= '0;
    else if (gmii_tx_en)
      en_run <= en_run + 8'd1;
    else
      en_run <= '0;
  end

  ack_single_cycle: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for two cycles");

  er_inside_frame: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
    gmii_tx_er |-> gmii_tx_en)
    else $error("gmii_tx_er high while gmii_tx_en is low");

  // Longest frame is 7 + 1 + 64 + 4 bytes
  en_max_length: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
    en_run <= 8'd76)
    else $error("gmii_tx_en high for more than 76 cycles");

endmodule

/* test/gmii_frame_gen_tb.sv */
`timescale 1ns/1ns
`include "gmii_params.svh"

module gmii_frame_gen_tb;

  localparam int ACK_LIMIT   = 20;
  localparam int START_LIMIT = 50;
  localparam int FRAME_LIMIT = 100;
  localparam int BUSY_LIMIT  = 100;
  localparam int NUM_TESTS   = 5;

  logic       gmii_tx_clk;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [6:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic [7:0] gmii_txd;
  logic       gmii_tx_en;
  logic       gmii_tx_er;

  // Frame table: name, length, error enable, error position
  string t_name [NUM_TESTS] = '{"len1", "len46_err17", "len60", "len64_err63", "len13_err0"};
  int    t_len [NUM_TESTS] = '{1, 46, 60, 64, 13};
  logic  t_err_en [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
  int    t_err_pos [NUM_TESTS] = '{0, 17, 0, 63, 0};

  integer     seed;
  string      cur_test;
  int         errors;
  int         err_mark;
  int         pass_cnt;
  int         fail_cnt;
  logic [7:0] rdata;
  logic [7:0] payload [64];
  logic [7:0] cap_d [FRAME_LIMIT];
  logic       cap_er [FRAME_LIMIT];
  int         cap_n;

  gmii_frame_gen i_gmii_frame_gen (.*);

  bind gmii_frame_gen gmii_frame_gen_props i_gmii_frame_gen_props (
    .gmii_tx_clk (gmii_tx_clk),
    .rst_n       (rst_n),
    .wb_ack      (wb_ack),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_tx_er  (gmii_tx_er)
  );

  initial gmii_tx_clk = 1'b0;
  always #10 gmii_tx_clk = ~gmii_tx_clk;

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
    else
    begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // One classic cycle, held until ack, read data kept in rdata
  task automatic wb_access(input logic we, input logic [6:0] adr, input logic [7:0] dat);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    @(posedge gmii_tx_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    while (!seen && n < ACK_LIMIT)
    begin
      @(negedge gmii_tx_clk);
      n++;
      if (wb_ack)
      begin
        seen  = 1'b1;
        rdata = wb_dat_r;
      end
    end
    assert (seen)
    else
    begin
      $display("ERROR %s: no wb_ack for address %0d", cur_test, adr);
      errors++;
    end
    @(posedge gmii_tx_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Reflected polynomial, all-ones start, inverted result
  function automatic logic [31:0] eth_crc32(input int len);
    logic [31:0] crc;
    crc = `CRC32_INIT;
    for (int i = 0; i < len; i++)
    begin
      crc = crc ^ {24'h0, payload[i]};
      for (int b = 0; b < 8; b++)
        crc = crc[0] ? ((crc >> 1) ^ `CRC32_POLY) : (crc >> 1);
    end
    return ~crc;
  endfunction

  task automatic capture_frame();
    int n;
    n = 0;
    cap_n = 0;
    while (!gmii_tx_en && n < START_LIMIT)
    begin
      @(negedge gmii_tx_clk);
      n++;
    end
    assert (gmii_tx_en)
    else
    begin
      $display("ERROR %s: gmii_tx_en never rose after start", cur_test);
      errors++;
    end
    while (gmii_tx_en && cap_n < FRAME_LIMIT)
    begin
      cap_d[cap_n]  = gmii_txd;
      cap_er[cap_n] = gmii_tx_er;
      cap_n++;
      @(negedge gmii_tx_clk);
    end
  endtask

  // Host traffic that must be ignored while the frame runs
  task automatic poke_while_busy();
    wb_access(1'b0, `REG_STATUS, 8'h00);
    check_value("STATUS busy", 1, 32'(rdata[0]));
    wb_access(1'b1, 7'd0, ~payload[0]);
    wb_access(1'b1, `REG_CTRL, 8'h01);
  endtask

  task automatic run_frame(input int ti);
    int len;
    int pos;
    int n;
    int last;
    integer rnd;
    logic [31:0] fcs;
    logic [7:0] exp;
    len = t_len[ti];
    pos = t_err_pos[ti];
    for (int i = 0; i < len; i++)
    begin
      rnd = $random(seed);
      payload[i] = rnd[7:0];
      wb_access(1'b1, i[6:0], payload[i]);
    end
    for (int i = 0; i < len; i++)
    begin
      wb_access(1'b0, i[6:0], 8'h00);
      check_value($sformatf("readback %0d", i), 32'(payload[i]), 32'(rdata));
    end
    wb_access(1'b1, `REG_LEN, 8'(len));
    wb_access(1'b1, `REG_ERR_POS, 8'(pos));
    wb_access(1'b1, `REG_CTRL, {6'b0, t_err_en[ti], 1'b1});
    fork
      capture_frame();
      poke_while_busy();
    join
    n = 0;
    rdata = 8'h01;
    while (rdata[0] && n < BUSY_LIMIT)
    begin
      wb_access(1'b0, `REG_STATUS, 8'h00);
      n++;
    end
    assert (!rdata[0])
    else
    begin
      $display("ERROR %s: busy never cleared", cur_test);
      errors++;
    end
    check_value("frame counter", (ti + 1) % 128, 32'(rdata[7:1]));
    for (int k = 0; k < 10; k++)
    begin
      @(negedge gmii_tx_clk);
      assert (!gmii_tx_en)
      else
      begin
        $display("ERROR %s: second frame after start while busy", cur_test);
        errors++;
      end
    end
    wb_access(1'b0, 7'd0, 8'h00);
    check_value("byte 0 after busy write", 32'(payload[0]), 32'(rdata));
    // Preamble 7, SFD 1, payload, FCS 4
    check_value("tx_en cycles", 12 + len, cap_n);
    fcs = eth_crc32(len);
    last = (cap_n < 12 + len) ? cap_n : 12 + len;
    for (int k = 0; k < last; k++)
    begin
      if (k < 7)
        exp = 8'h55;
      else if (k == 7)
        exp = 8'hD5;
      else if (k < 8 + len)
        exp = payload[k - 8];
      else
        exp = fcs[8 * (k - 8 - len) +: 8];
      check_value($sformatf("txd %0d", k), 32'(exp), 32'(cap_d[k]));
      check_value($sformatf("tx_er %0d", k), 32'(t_err_en[ti] && (k == 8 + pos)),
                  32'(cap_er[k]));
    end
  endtask

  task automatic report_test();
    if (errors == err_mark)
    begin
      pass_cnt++;
      $display("%-12s PASS", cur_test);
    end
    else
    begin
      fail_cnt++;
      $display("%-12s FAIL", cur_test);
    end
  endtask

  initial
  begin
    seed     = 32'h2b8e_992e;
    errors   = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    repeat (2) @(posedge gmii_tx_clk);
    rst_n <= 1'b1;
    cur_test = "reset";
    err_mark = errors;
    @(negedge gmii_tx_clk);
    check_value("gmii_tx_en", 0, 32'(gmii_tx_en));
    check_value("gmii_tx_er", 0, 32'(gmii_tx_er));
    check_value("gmii_txd", 0, 32'(gmii_txd));
    check_value("wb_ack", 0, 32'(wb_ack));
    wb_access(1'b0, `REG_STATUS, 8'h00);
    check_value("STATUS", 0, 32'(rdata));
    report_test();
    for (int ti = 0; ti < NUM_TESTS; ti++)
    begin
      cur_test = t_name[ti];
      err_mark = errors;
      run_frame(ti);
      report_test();
    end
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
